/* flist.f */
+incdir+include
hdl/ooo_pkg.sv
hdl/uop_decoder.sv
hdl/rename_table.sv
hdl/dispatch.sv
hdl/alu_exec.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
sim/ooo_core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/ooo_pkg.sv
      - hdl/uop_decoder.sv
      - hdl/rename_table.sv
      - hdl/dispatch.sv
      - hdl/alu_exec.sv
      - hdl/reorder_buffer.sv
      - hdl/ooo_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/ooo_core_tb.sv

/* sim/ooo_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_settings.svh"

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 1000;

    typedef struct packed {
        logic [`OOO_PC_W-1:0]   pc;
        logic [`OOO_ARCH_W-1:0] rd;
        logic [`OOO_XLEN-1:0]   value;
        logic                   except;
        logic [2:0]             test_id;
    } expect_t;

    logic                 clk;
    logic                 rst;
    logic                 instr_valid;
    instr_word_t          instr;
    logic [`OOO_PC_W-1:0] instr_pc;
    logic                 stall;
    commit_t              commit;

    logic [`OOO_XLEN-1:0] arch_regs [`OOO_ARCH_REGS];    // architectural model
    expect_t              exp_q [$];
    integer               seed;
    int                   stall_cycles;
    logic [`OOO_PC_W-1:0] next_pc;

    ooo_core ooo_core_inst (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .stall       (stall),
        .commit      (commit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "imm_form";
            3'd1:    return "reg_form";
            3'd2:    return "dep_chain";
            3'd3:    return "illegal";
            default: return "random_mix";
        endcase
    endfunction

    // legal opcodes are 0 to 6 and 8 to 14
    function automatic logic is_illegal(input logic [4:0] opc);
        return !((opc <= 5'd6) || ((opc >= 5'd8) && (opc <= 5'd14)));
    endfunction

    function automatic logic [`OOO_XLEN-1:0] sign_extend(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [`OOO_XLEN-1:0] expected_result(input logic [2:0] op,
            input logic [`OOO_XLEN-1:0] a, input logic [`OOO_XLEN-1:0] b);
        case (op)
            3'd0:    return a + b;
            3'd1:    return a - b;
            3'd2:    return a & b;
            3'd3:    return a | b;
            3'd4:    return a ^ b;
            3'd5:    return a << b[4:0];    // shift amount is 5 bits
            default: return a >> b[4:0];
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    // commit is registered and stable at the falling edge
    always @(negedge clk) begin : commit_check
        expect_t e;
        if (!rst && stall) begin
            stall_cycles++;
        end
        if (!rst && commit.valid) begin
            assert (exp_q.size() != 0)
                else report_failure("commit seen with no instruction outstanding");
            e = exp_q.pop_front();
            assert (commit.pc == e.pc)
                else report_failure($sformatf("Mismatch %s pc: expected %h actual %h",
                                              test_name(e.test_id), e.pc, commit.pc));
            assert (commit.except == e.except)
                else report_failure($sformatf(
                    "Mismatch %s except at pc %h: expected %b actual %b",
                    test_name(e.test_id), e.pc, e.except, commit.except));
            if (!e.except) begin
                assert (commit.dest_arch == e.rd)
                    else report_failure($sformatf(
                        "Mismatch %s rd at pc %h: expected %0d actual %0d",
                        test_name(e.test_id), e.pc, e.rd, commit.dest_arch));
                assert (commit.value == e.value)
                    else report_failure($sformatf(
                        "Mismatch %s value at pc %h: expected %h actual %h",
                        test_name(e.test_id), e.pc, e.value, commit.value));
            end
        end
    end

    task automatic idle(input int n);
        instr_valid = 1'b0;
        repeat (n) @(posedge clk);
        #1;
    endtask

    // queue the model result and hold the word until the core takes it
    task automatic issue(input logic [4:0] opc, input logic [2:0] rd, input logic [2:0] rs1,
                         input logic [2:0] rs2, input logic [15:0] imm, input logic [2:0] test_id);
        expect_t              e;
        logic [`OOO_XLEN-1:0] op2;
        logic [31:0]          word;
        logic                 accepted;
        int                   waited;
        e.pc      = next_pc;
        e.rd      = rd;
        e.test_id = test_id;
        e.except  = is_illegal(opc);
        e.value   = '0;
        if (!e.except) begin
            op2           = opc[3] ? sign_extend(imm) : arch_regs[rs2];
            e.value       = expected_result(opc[2:0], arch_regs[rs1], op2);
            arch_regs[rd] = e.value;
        end
        exp_q.push_back(e);
        if (opc[3]) begin
            word = {opc, rd, rs1, 5'b0, imm};
        end else begin
            word = {opc, rd, rs1, rs2, 18'b0};
        end
        instr       = word;
        instr_pc    = next_pc;
        instr_valid = 1'b1;
        accepted    = 1'b0;
        waited      = 0;
        while (!accepted) begin
            @(negedge clk);
            accepted = !stall;
            @(posedge clk);
            #1;
            waited++;
            if (!accepted && waited > ACCEPT_LIMIT) begin
                report_failure($sformatf("instruction at pc %h was never accepted", next_pc));
            end
        end
        next_pc = next_pc + 4;
    endtask

    task automatic issue_random(input logic [2:0] test_id);
        logic [31:0] r;
        logic [31:0] k;
        logic [4:0]  opc;
        r = $random(seed);
        k = $random(seed);
        if (r[31:29] == 3'd0) begin
            opc = r[5] ? {1'b1, r[3:0]} : (r[4] ? 5'd15 : 5'd7);
        end else begin
            opc = {1'b0, r[6], 3'(r[10:8] % 7)};
        end
        issue(opc, r[13:11], r[16:14], r[19:17], k[15:0], test_id);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        logic [2:0]  prev;
        int          waited;
        seed         = 32'h981faa57;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        instr_pc     = '0;
        next_pc      = 32'h0000_1000;
        stall_cycles = 0;
        for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
            arch_regs[i] = '0;
        end

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (3) begin
            @(negedge clk);
            assert (!stall && !commit.valid)
                else report_failure("stall or commit active before the first instruction");
        end
        @(posedge clk);
        #1;

        for (int i = 0; i < `OOO_ARCH_REGS; i++) begin    // seed every register with addi
            r = $random(seed);
            issue(5'd8, 3'(i), 3'(i), 3'd0, r[15:0], 3'd0);
        end
        for (int n = 0; n < 2; n++) begin
            for (int op = 8; op < 15; op++) begin
                r = $random(seed);
                issue(5'(op), r[18:16], r[21:19], 3'd0, r[15:0], 3'd0);
            end
        end

        for (int n = 0; n < 2; n++) begin
            for (int op = 0; op < 7; op++) begin
                r = $random(seed);
                issue(5'(op), r[2:0], r[5:3], r[8:6], 16'h0, 3'd1);
            end
        end

        prev = 3'd1;
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            issue({1'b0, r[20], 3'(r[23:21] % 7)}, r[2:0], prev, prev, r[15:0], 3'd2);
            prev = r[2:0];
        end

        issue(5'd7, 3'd2, 3'd1, 3'd3, 16'h0, 3'd3);
        issue(5'd15, 3'd2, 3'd4, 3'd0, 16'h1234, 3'd3);
        issue(5'd16, 3'd5, 3'd2, 3'd2, 16'h0, 3'd3);
        issue(5'd31, 3'd2, 3'd6, 3'd7, 16'hffff, 3'd3);
        issue(5'd0, 3'd4, 3'd2, 3'd2, 16'h0, 3'd3);    // readers of the untouched registers
        issue(5'd12, 3'd6, 3'd5, 3'd0, 16'h00ff, 3'd3);

        for (int i = 0; i < 300; i++) begin
            issue_random(3'd4);
            r = $random(seed);
            if (r[3:0] == 4'd0) begin
                idle(1 + r[5:4]);
            end
        end

        instr_valid = 1'b0;
        waited      = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > DRAIN_LIMIT) begin
                report_failure("commits stopped before every instruction retired");
            end
        end
        idle(5);

        if (stall_cycles > 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            report_failure("the core never raised stall during the run");
        end
    end

endmodule

`default_nettype wire

/* hdl/ooo_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_settings.svh"

module ooo_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_valid,
    input  ooo_pkg::instr_word_t instr,
    input  logic [`OOO_PC_W-1:0] instr_pc,
    output logic                 stall,
    output ooo_pkg::commit_t     commit
);
    import ooo_pkg::*;

    logic                  dec_valid;
    decoded_t              dec;
    logic                  src1_rdy;
    logic                  src2_rdy;
    logic [`OOO_TAG_W-1:0] src1_tag;
    logic [`OOO_TAG_W-1:0] src2_tag;
    logic [`OOO_XLEN-1:0]  src1_val;
    logic [`OOO_XLEN-1:0]  src2_val;
    logic [`OOO_TAG_W-1:0] dest_tag;
    logic [`OOO_TAG_W-1:0] dest_oldtag;
    logic                  free_empty;
    logic                  free_valid;
    logic [`OOO_TAG_W-1:0] free_tag;
    logic [`OOO_ROB_W-1:0] rob_tail;
    logic                  rob_full;
    logic                  disp_valid;
    dispatch_t             disp;
    logic                  alloc;
    rob_alloc_t            alloc_info;
    result_t               result;
    logic                  alu_busy;

    // only a decoded uop can be held back
    assign stall = dec_valid & (rob_full | free_empty | alu_busy);

    uop_decoder uop_decoder_inst (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .stall       (stall),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    rename_table rename_table_inst (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec         (dec),
        .stall       (stall),
        .result      (result),
        .free_valid  (free_valid),
        .free_tag    (free_tag),
        .src1_rdy    (src1_rdy),
        .src2_rdy    (src2_rdy),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .src1_val    (src1_val),
        .src2_val    (src2_val),
        .dest_tag    (dest_tag),
        .dest_oldtag (dest_oldtag),
        .free_empty  (free_empty)
    );

    dispatch dispatch_inst (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec         (dec),
        .stall       (stall),
        .src1_rdy    (src1_rdy),
        .src2_rdy    (src2_rdy),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .src1_val    (src1_val),
        .src2_val    (src2_val),
        .dest_tag    (dest_tag),
        .dest_oldtag (dest_oldtag),
        .rob_tail    (rob_tail),
        .disp_valid  (disp_valid),
        .disp        (disp),
        .alloc       (alloc),
        .alloc_info  (alloc_info)
    );

    alu_exec alu_exec_inst (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp       (disp),
        .result     (result),
        .busy       (alu_busy)
    );

    reorder_buffer reorder_buffer_inst (
        .clk        (clk),
        .rst        (rst),
        .alloc      (alloc),
        .alloc_info (alloc_info),
        .result     (result),
        .rob_tail   (rob_tail),
        .rob_full   (rob_full),
        .commit     (commit),
        .free_valid (free_valid),
        .free_tag   (free_tag)
    );

endmodule

`default_nettype wire

/* hdl/reorder_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_settings.svh"

module reorder_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc,
    input  ooo_pkg::rob_alloc_t   alloc_info,
    input  ooo_pkg::result_t      result,
    output logic [`OOO_ROB_W-1:0] rob_tail,
    output logic                  rob_full,
    output ooo_pkg::commit_t      commit,
    output logic                  free_valid,
    output logic [`OOO_TAG_W-1:0] free_tag
);
    import ooo_pkg::*;

    rob_alloc_t               info  [`OOO_ROB_SIZE];
    logic [`OOO_XLEN-1:0]     value [`OOO_ROB_SIZE];
    logic [`OOO_ROB_SIZE-1:0] done;
    logic [`OOO_ROB_W-1:0]    head;
    logic [`OOO_ROB_W-1:0]    tail;
    logic [`OOO_ROB_W:0]      count;
    logic                     retire;

    assign retire = (count != '0) & done[head];

    // an alloc still in flight already owns the current tail
    assign rob_tail = tail + alloc;
    assign rob_full = ((count + alloc) == `OOO_ROB_SIZE);

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done         <= '0;
            commit.valid <= 1'b0;
            free_valid   <= 1'b0;
        end else begin
            if (alloc) begin
                done[tail] <= alloc_info.except;    // illegal entries are done at once
                tail       <= tail + 1'b1;
            end
            if (result.valid) begin
                done[result.rob_entry] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count        <= count + alloc - retire;
            commit.valid <= retire;
            free_valid   <= retire & ~info[head].except;
        end

        if (alloc) begin
            info[tail] <= alloc_info;
        end
        if (result.valid) begin
            value[result.rob_entry] <= result.value;
        end

        if (retire) begin
            commit.pc        <= info[head].pc;
            commit.dest_arch <= info[head].dest_arch;
            commit.value     <= value[head];
            commit.except    <= info[head].except;
            free_tag         <= info[head].dest_oldphys;    // previous mapping is dead now
        end
    end

endmodule

`default_nettype wire

/* hdl/alu_exec.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_settings.svh"

module alu_exec (
    input  logic               clk,
    input  logic               rst,
    input  logic               disp_valid,
    input  ooo_pkg::dispatch_t disp,
    output ooo_pkg::result_t   result,
    output logic               busy
);
    import ooo_pkg::*;

    logic                 slot_valid;
    dispatch_t            slot;
    logic                 fire;
    logic [`OOO_XLEN-1:0] alu_out;

    // capture any operand the broadcast is carrying
    function automatic dispatch_t wake(input dispatch_t e, input result_t r);
        dispatch_t w;
        w = e;
        if (r.valid && !e.op1_rdy && (r.tag == e.op1_tag)) begin
            w.op1_rdy = 1'b1;
            w.op1_val = r.value;
        end
        if (r.valid && !e.op2_rdy && (r.tag == e.op2_tag)) begin
            w.op2_rdy = 1'b1;
            w.op2_val = r.value;
        end
        return w;
    endfunction

    assign fire = slot_valid & slot.op1_rdy & slot.op2_rdy;
    assign busy = disp_valid | (slot_valid & ~fire);    // an incoming uop fills the slot

    always_comb begin
        case (slot.uop)
            UOP_ADD: alu_out = slot.op1_val + slot.op2_val;
            UOP_SUB: alu_out = slot.op1_val - slot.op2_val;
            UOP_AND: alu_out = slot.op1_val & slot.op2_val;
            UOP_OR:  alu_out = slot.op1_val | slot.op2_val;
            UOP_XOR: alu_out = slot.op1_val ^ slot.op2_val;
            UOP_SLL: alu_out = slot.op1_val << slot.op2_val[4:0];
            UOP_SRL: alu_out = slot.op1_val >> slot.op2_val[4:0];
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid   <= 1'b0;
            result.valid <= 1'b0;
        end else begin
            result.valid <= fire;
            if (disp_valid) begin
                slot_valid <= 1'b1;
            end else if (fire) begin
                slot_valid <= 1'b0;
            end
        end
        if (fire) begin
            result.tag       <= slot.dest_tag;
            result.rob_entry <= slot.rob_entry;
            result.value     <= alu_out;
        end
        slot <= disp_valid ? wake(disp, result) : wake(slot, result);
    end

endmodule

`default_nettype wire

/* hdl/dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_settings.svh"

module dispatch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dec_valid,
    input  ooo_pkg::decoded_t     dec,
    input  logic                  stall,
    input  logic                  src1_rdy,
    input  logic                  src2_rdy,
    input  logic [`OOO_TAG_W-1:0] src1_tag,
    input  logic [`OOO_TAG_W-1:0] src2_tag,
    input  logic [`OOO_XLEN-1:0]  src1_val,
    input  logic [`OOO_XLEN-1:0]  src2_val,
    input  logic [`OOO_TAG_W-1:0] dest_tag,
    input  logic [`OOO_TAG_W-1:0] dest_oldtag,
    input  logic [`OOO_ROB_W-1:0] rob_tail,
    output logic                  disp_valid,
    output ooo_pkg::dispatch_t    disp,
    output logic                  alloc,
    output ooo_pkg::rob_alloc_t   alloc_info
);
    logic go;

    assign go = dec_valid & ~stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            disp_valid <= 1'b0;
            alloc      <= 1'b0;
        end else begin
            disp_valid <= go & ~dec.except;    // illegal uops skip the alu
            alloc      <= go;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            disp.uop       <= dec.uop;
            disp.op1_rdy   <= src1_rdy;
            disp.op1_tag   <= src1_tag;
            disp.op1_val   <= src1_val;
            disp.op2_rdy   <= dec.use_imm ? 1'b1 : src2_rdy;
            disp.op2_tag   <= dec.use_imm ? '0 : src2_tag;
            disp.op2_val   <= dec.use_imm ? dec.imm : src2_val;
            disp.dest_tag  <= dest_tag;
            disp.rob_entry <= rob_tail;

            alloc_info.pc           <= dec.pc;
            alloc_info.dest_arch    <= dec.rd;
            alloc_info.dest_phys    <= dest_tag;
            alloc_info.dest_oldphys <= dest_oldtag;
            alloc_info.except       <= dec.except;
        end
    end

endmodule

`default_nettype wire

/* hdl/rename_table.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_settings.svh"

module rename_table (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dec_valid,
    input  ooo_pkg::decoded_t     dec,
    input  logic                  stall,
    input  ooo_pkg::result_t      result,
    input  logic                  free_valid,
    input  logic [`OOO_TAG_W-1:0] free_tag,
    output logic                  src1_rdy,
    output logic                  src2_rdy,
    output logic [`OOO_TAG_W-1:0] src1_tag,
    output logic [`OOO_TAG_W-1:0] src2_tag,
    output logic [`OOO_XLEN-1:0]  src1_val,
    output logic [`OOO_XLEN-1:0]  src2_val,
    output logic [`OOO_TAG_W-1:0] dest_tag,
    output logic [`OOO_TAG_W-1:0] dest_oldtag,
    output logic                  free_empty
);
    typedef logic [`OOO_TAG_W-1:0] tag_t;
    typedef logic [`OOO_TAG_W:0]   fl_cnt_t;

    tag_t                      alias_tab [`OOO_ARCH_REGS];
    logic [`OOO_XLEN-1:0]      prf       [`OOO_PHYS_REGS];
    logic [`OOO_PHYS_REGS-1:0] prf_rdy;
    tag_t                      fl_mem    [`OOO_PHYS_REGS];
    tag_t                      fl_head;
    tag_t                      fl_tail;
    fl_cnt_t                   fl_count;
    logic                      rename;
    logic                      fwd1;
    logic                      fwd2;

    assign rename = dec_valid & ~stall & ~dec.except;    // illegal uops take no tag

    assign src1_tag = alias_tab[dec.rs1];
    assign src2_tag = alias_tab[dec.rs2];

    // result landing this cycle is not in the prf yet
    assign fwd1 = result.valid & (result.tag == src1_tag);
    assign fwd2 = result.valid & (result.tag == src2_tag);

    assign src1_rdy = prf_rdy[src1_tag] | fwd1;
    assign src2_rdy = prf_rdy[src2_tag] | fwd2;
    assign src1_val = fwd1 ? result.value : prf[src1_tag];
    assign src2_val = fwd2 ? result.value : prf[src2_tag];

    assign dest_tag    = fl_mem[fl_head];
    assign dest_oldtag = alias_tab[dec.rd];
    assign free_empty  = (fl_count == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity mapping, upper tags start out free
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                alias_tab[i] <= tag_t'(i);
                fl_mem[i]    <= tag_t'(i + `OOO_ARCH_REGS);
            end
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                prf[i] <= '0;
            end
            prf_rdy  <= '1;
            fl_head  <= '0;
            fl_tail  <= tag_t'(`OOO_ARCH_REGS);
            fl_count <= fl_cnt_t'(`OOO_PHYS_REGS - `OOO_ARCH_REGS);
        end else begin
            if (result.valid) begin
                prf[result.tag]     <= result.value;
                prf_rdy[result.tag] <= 1'b1;
            end
            if (rename) begin
                alias_tab[dec.rd] <= dest_tag;
                prf_rdy[dest_tag] <= 1'b0;
                fl_head           <= fl_head + 1'b1;
            end
            if (free_valid) begin
                fl_mem[fl_tail] <= free_tag;
                fl_tail         <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + free_valid - rename;
        end
    end

endmodule

`default_nettype wire

/* hdl/uop_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_settings.svh"

module uop_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_valid,
    input  ooo_pkg::instr_word_t instr,
    input  logic [`OOO_PC_W-1:0] instr_pc,
    input  logic                 stall,
    output logic                 dec_valid,
    output ooo_pkg::decoded_t    dec
);
    import ooo_pkg::*;

    decoded_t              next_dec;
    logic [`OOO_OPC_W-1:0] opc;

    assign opc = instr.r_fmt.opcode;    // same bits in both forms

    always_comb begin
        next_dec         = '0;
        next_dec.pc      = instr_pc;
        next_dec.use_imm = opc[3];
        next_dec.except  = opc[4] | (opc[2:0] == 3'd7);
        next_dec.rd      = instr.r_fmt.rd;    // rd and rs1 sit alike in both forms
        next_dec.rs1     = instr.r_fmt.rs1;
        if (!next_dec.except) begin
            next_dec.uop = uop_e'({1'b0, opc[2:0]});
        end
        if (opc[3]) begin
            next_dec.imm = {{(`OOO_XLEN-`OOO_IMM_W){instr.i_fmt.imm[`OOO_IMM_W-1]}},
                            instr.i_fmt.imm};
        end else begin
            next_dec.rs2 = instr.r_fmt.rs2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= instr_valid;
        end
    end

    // payload only moves when a new word is taken
    always_ff @(posedge clk) begin
        if (!stall && instr_valid) begin
            dec <= next_dec;
        end
    end

endmodule

`default_nettype wire

/* hdl/ooo_pkg.sv */
`default_nettype none

`include "ooo_settings.svh"

package ooo_pkg;

    typedef struct packed {
        logic [`OOO_OPC_W-1:0]  opcode;
        logic [`OOO_ARCH_W-1:0] rd;
        logic [`OOO_ARCH_W-1:0] rs1;
        logic [`OOO_ARCH_W-1:0] rs2;
        logic [17:0]            pad;
    } r_fmt_t;

    typedef struct packed {
        logic [`OOO_OPC_W-1:0]  opcode;
        logic [`OOO_ARCH_W-1:0] rd;
        logic [`OOO_ARCH_W-1:0] rs1;
        logic [4:0]             pad;
        logic [`OOO_IMM_W-1:0]  imm;    // sign-extended on decode
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_word_t;

    // opcode[2:0] selects the uop, opcode[3] the immediate form
    typedef enum logic [`OOO_UOP_W-1:0] {
        UOP_ADD = 4'd0,
        UOP_SUB = 4'd1,
        UOP_AND = 4'd2,
        UOP_OR  = 4'd3,
        UOP_XOR = 4'd4,
        UOP_SLL = 4'd5,
        UOP_SRL = 4'd6
    } uop_e;

    typedef struct packed {
        uop_e                   uop;
        logic                   use_imm;
        logic [`OOO_XLEN-1:0]   imm;
        logic [`OOO_ARCH_W-1:0] rs1;
        logic [`OOO_ARCH_W-1:0] rs2;
        logic [`OOO_ARCH_W-1:0] rd;
        logic [`OOO_PC_W-1:0]   pc;
        logic                   except;
    } decoded_t;

    typedef struct packed {
        uop_e                  uop;
        logic                  op1_rdy;
        logic [`OOO_TAG_W-1:0] op1_tag;
        logic [`OOO_XLEN-1:0]  op1_val;
        logic                  op2_rdy;
        logic [`OOO_TAG_W-1:0] op2_tag;
        logic [`OOO_XLEN-1:0]  op2_val;
        logic [`OOO_TAG_W-1:0] dest_tag;
        logic [`OOO_ROB_W-1:0] rob_entry;
    } dispatch_t;

    typedef struct packed {
        logic [`OOO_PC_W-1:0]   pc;
        logic [`OOO_ARCH_W-1:0] dest_arch;
        logic [`OOO_TAG_W-1:0]  dest_phys;
        logic [`OOO_TAG_W-1:0]  dest_oldphys;
        logic                   except;
    } rob_alloc_t;

    typedef struct packed {
        logic                  valid;
        logic [`OOO_TAG_W-1:0] tag;
        logic [`OOO_ROB_W-1:0] rob_entry;
        logic [`OOO_XLEN-1:0]  value;
    } result_t;

    typedef struct packed {
        logic                   valid;
        logic [`OOO_PC_W-1:0]   pc;
        logic [`OOO_ARCH_W-1:0] dest_arch;
        logic [`OOO_XLEN-1:0]   value;
        logic                   except;
    } commit_t;

endpackage

`default_nettype wire

/* include/ooo_settings.svh */
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// datapath and pc
`define OOO_XLEN       32
`define OOO_PC_W       32

// instruction word fields
`define OOO_OPC_W      5
`define OOO_IMM_W      16
`define OOO_UOP_W      4

// register files
`define OOO_ARCH_REGS  8
`define OOO_ARCH_W     3
`define OOO_PHYS_REGS  16
`define OOO_TAG_W      4

// reorder buffer
`define OOO_ROB_SIZE   8
`define OOO_ROB_W      3

`endif
